// File: source/osdPkg.sv
package osdPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // One register, one I2C data byte and one character cell are all a byte wide
    localparam int regWidth = 8;

    // Character memory address, split into a page and a 7 bit offset
    localparam int charAddrWidth = 10;

    // Eight pages of 128 characters each
    localparam int pageWidth = 3;

    // Controller button word and the video frame counter
    localparam int ctrlWidth = 12;
    localparam int frameWidth = 10;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    // Pointers below regPage land in the character memory window
    localparam logic [regWidth-1:0] regPage = 8'h80;
    localparam logic [regWidth-1:0] regEnable = 8'h81;
    localparam logic [regWidth-1:0] regHighlight = 8'h82;

    // Controller buttons, upper byte and then the low nibble shifted up
    localparam logic [regWidth-1:0] regCtrlHigh = 8'h85;
    localparam logic [regWidth-1:0] regCtrlLow = 8'h86;

    // Video debug values
    localparam logic [regWidth-1:0] regPllErrors = 8'h90;
    localparam logic [regWidth-1:0] regFrameLow = 8'h92;
    localparam logic [regWidth-1:0] regFrameHigh = 8'h93;
    localparam logic [regWidth-1:0] regRestarts = 8'h9B;

    // Line the OSD menu highlights when it comes out of reset
    localparam logic [regWidth-1:0] highlightReset = 8'd7;

endpackage

// File: source/i2cTarget.sv
`timescale 1ns/1ns

module i2cTarget #(
    parameter logic [6:0] deviceAddr = 7'h00
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         scl,
    input  logic                         sdaIn,
    output logic                         sdaDriveLow,
    output logic [osdPkg::regWidth-1:0]  regAddr,
    output logic [osdPkg::regWidth-1:0]  regWrData,
    output logic                         regWrite,
    input  logic [osdPkg::regWidth-1:0]  regRdData
);
    import osdPkg::*;

    // Bit level states of the target
    localparam logic [2:0] stIdle    = 3'd0;
    localparam logic [2:0] stAddr    = 3'd1;
    localparam logic [2:0] stAddrAck = 3'd2;
    localparam logic [2:0] stPointer = 3'd3;
    localparam logic [2:0] stWrData  = 3'd4;
    localparam logic [2:0] stWrAck   = 3'd5;
    localparam logic [2:0] stRdData  = 3'd6;
    localparam logic [2:0] stRdAck   = 3'd7;

    logic                sclMeta;
    logic                sclSync;
    logic                sclPrev;
    logic                sdaMeta;
    logic                sdaSync;
    logic                sdaPrev;
    logic                sclRise;
    logic                sclFall;
    logic                startCond;
    logic                stopCond;
    logic [2:0]          state;
    logic [3:0]          bitCnt;
    logic [regWidth-1:0] shiftReg;
    logic                rwBit;

    ////////////////////////////////////////////////////////////////////////////
    // Bus synchroniser and edge detection
    ////////////////////////////////////////////////////////////////////////////

    // Both lines idle high, so the flops come out of reset high
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sclMeta <= 1'b1;
            sclSync <= 1'b1;
            sclPrev <= 1'b1;
            sdaMeta <= 1'b1;
            sdaSync <= 1'b1;
            sdaPrev <= 1'b1;
        end else begin
            sclMeta <= scl;
            sclSync <= sclMeta;
            sclPrev <= sclSync;
            sdaMeta <= sdaIn;
            sdaSync <= sdaMeta;
            sdaPrev <= sdaSync;
        end
    end

    assign sclRise = sclSync & ~sclPrev;
    assign sclFall = ~sclSync & sclPrev;

    // Sda may only move while scl is high for a start or a stop
    assign startCond = sclSync & sclPrev & sdaPrev & ~sdaSync;
    assign stopCond  = sclSync & sclPrev & ~sdaPrev & sdaSync;

    ////////////////////////////////////////////////////////////////////////////
    // Byte FSM
    ////////////////////////////////////////////////////////////////////////////

    // Data is taken at rising scl, sda is only ever driven after falling scl
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state       <= stIdle;
            bitCnt      <= 4'd0;
            sdaDriveLow <= 1'b0;
            regAddr     <= '0;
            regWrite    <= 1'b0;
        end else begin
            regWrite <= 1'b0;
            // The pointer moves on once the register file has taken the byte
            if (regWrite) begin
                regAddr <= regAddr + 1'b1;
            end
            if (startCond) begin
                state  <= stAddr;
                bitCnt <= 4'd0;
            end else if (stopCond) begin
                state <= stIdle;
            end else begin
                case (state)
                    stAddr: begin
                        if (sclRise) begin
                            shiftReg <= {shiftReg[regWidth-2:0], sdaSync};
                            bitCnt   <= bitCnt + 4'd1;
                        end else if (sclFall && bitCnt == 4'd8) begin
                            // A foreign address leaves the bus alone until the next start
                            if (shiftReg[regWidth-1:1] == deviceAddr) begin
                                state       <= stAddrAck;
                                sdaDriveLow <= 1'b1;
                                rwBit       <= shiftReg[0];
                            end else begin
                                state <= stIdle;
                            end
                        end
                    end
                    stAddrAck, stRdAck: begin
                        if (state == stRdAck && sclRise && sdaSync) begin
                            // Master NACK closes the read
                            state <= stIdle;
                        end else if (sclFall) begin
                            bitCnt <= 4'd0;
                            if (state == stRdAck || rwBit) begin
                                // Load the next read byte and put its MSB on the bus
                                state       <= stRdData;
                                shiftReg    <= regRdData;
                                sdaDriveLow <= ~regRdData[regWidth-1];
                                regAddr     <= regAddr + 1'b1;
                            end else begin
                                state       <= stPointer;
                                sdaDriveLow <= 1'b0;
                            end
                        end
                    end
                    stPointer, stWrData: begin
                        if (sclRise) begin
                            shiftReg <= {shiftReg[regWidth-2:0], sdaSync};
                            bitCnt   <= bitCnt + 4'd1;
                            // Eighth bit of a data byte raises the write strobe
                            if (state == stWrData && bitCnt == 4'd7) begin
                                regWrData <= {shiftReg[regWidth-2:0], sdaSync};
                                regWrite  <= 1'b1;
                            end
                        end else if (sclFall && bitCnt == 4'd8) begin
                            if (state == stPointer) begin
                                regAddr <= shiftReg;
                            end
                            state       <= stWrAck;
                            sdaDriveLow <= 1'b1;
                        end
                    end
                    stWrAck: begin
                        if (sclFall) begin
                            state       <= stWrData;
                            sdaDriveLow <= 1'b0;
                            bitCnt      <= 4'd0;
                        end
                    end
                    stRdData: begin
                        if (sclRise) begin
                            bitCnt <= bitCnt + 4'd1;
                        end else if (sclFall) begin
                            if (bitCnt == 4'd8) begin
                                // Release sda so the master can answer
                                state       <= stRdAck;
                                sdaDriveLow <= 1'b0;
                            end else begin
                                shiftReg    <= {shiftReg[regWidth-2:0], 1'b0};
                                sdaDriveLow <= ~shiftReg[regWidth-2];
                            end
                        end
                    end
                    default: begin
                        // Idle waits for a start only
                    end
                endcase
            end
        end
    end

endmodule

// File: source/osdRegisterFile.sv
`timescale 1ns/1ns

module osdRegisterFile (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [osdPkg::regWidth-1:0]       regAddr,
    input  logic [osdPkg::regWidth-1:0]       regWrData,
    input  logic                              regWrite,
    output logic [osdPkg::regWidth-1:0]       regRdData,
    output logic [osdPkg::charAddrWidth-1:0]  ramWrAddr,
    output logic [osdPkg::regWidth-1:0]       ramWrData,
    output logic                              ramWrite,
    output logic                              enableOsd,
    output logic [osdPkg::regWidth-1:0]       highlightLine,
    input  logic [osdPkg::ctrlWidth-1:0]      controllerData,
    input  logic [osdPkg::regWidth-1:0]       pllErrors,
    input  logic [osdPkg::frameWidth-1:0]     frameCounter,
    input  logic [osdPkg::regWidth-1:0]       restartCount
);
    import osdPkg::*;

    // Page offset placed above the 7 pointer bits of a memory write
    logic [pageWidth-1:0] page;
    logic                 inCharWindow;

    // The low half of the pointer space maps straight onto the current page
    assign inCharWindow = regAddr < regPage;

    ////////////////////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////////////////////

    // Refreshed every cycle, so the byte is ready long before the target loads it
    always_ff @(posedge clk) begin
        case (regAddr)
            regPage:      regRdData <= {{(regWidth-pageWidth){1'b0}}, page};
            regEnable:    regRdData <= {{(regWidth-1){1'b0}}, enableOsd};
            regCtrlHigh:  regRdData <= controllerData[ctrlWidth-1:4];
            // Buttons 3 to 0 sit in the upper nibble
            regCtrlLow:   regRdData <= {controllerData[3:0], 4'b0000};
            regPllErrors: regRdData <= pllErrors;
            regFrameLow:  regRdData <= frameCounter[7:0];
            regFrameHigh: regRdData <= {{(2*regWidth-frameWidth){1'b0}}, frameCounter[9:8]};
            regRestarts:  regRdData <= restartCount;
            // Highlight is write only and reads back as zero like any gap
            default:      regRdData <= '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            page          <= '0;
            enableOsd     <= 1'b0;
            highlightLine <= highlightReset;
            ramWrite      <= 1'b0;
        end else begin
            ramWrite <= 1'b0;
            if (regWrite) begin
                if (inCharWindow) begin
                    ramWrite <= 1'b1;
                end else begin
                    // Other addresses from 0x80 up drop the write
                    case (regAddr)
                        regPage:      page <= regWrData[pageWidth-1:0];
                        regEnable:    enableOsd <= regWrData[0];
                        regHighlight: highlightLine <= regWrData;
                        default:      ;
                    endcase
                end
            end
        end
    end

    // Memory address and byte go out together with the write pulse
    always_ff @(posedge clk) begin
        if (regWrite && inCharWindow) begin
            ramWrAddr <= {page, regAddr[charAddrWidth-pageWidth-1:0]};
            ramWrData <= regWrData;
        end
    end

endmodule

// File: source/osdCharRam.sv
`timescale 1ns/1ns

module osdCharRam (
    input  logic                              clk,
    input  logic [osdPkg::charAddrWidth-1:0]  ramWrAddr,
    input  logic [osdPkg::regWidth-1:0]       ramWrData,
    input  logic                              ramWrite,
    input  logic [osdPkg::charAddrWidth-1:0]  dispAddr,
    output logic [osdPkg::regWidth-1:0]       dispData
);
    import osdPkg::*;

    // One byte per character cell, eight pages of 128
    logic [regWidth-1:0] charMem [0:(1<<charAddrWidth)-1];

    ////////////////////////////////////////////////////////////////////////////
    // Register file port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ramWrite) begin
            charMem[ramWrAddr] <= ramWrData;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Display port
    ////////////////////////////////////////////////////////////////////////////

    // Registered output, the renderer sees the byte one cycle after the address
    always_ff @(posedge clk) begin
        dispData <= charMem[dispAddr];
    end

endmodule

// File: source/osdControlTop.sv
`timescale 1ns/1ns

module osdControlTop #(
    parameter logic [6:0] deviceAddr = 7'h29
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              scl,
    input  logic                              sdaIn,
    output logic                              sdaDriveLow,
    input  logic [osdPkg::ctrlWidth-1:0]      controllerData,
    input  logic [osdPkg::regWidth-1:0]       pllErrors,
    input  logic [osdPkg::frameWidth-1:0]     frameCounter,
    input  logic [osdPkg::regWidth-1:0]       restartCount,
    input  logic [osdPkg::charAddrWidth-1:0]  dispAddr,
    output logic [osdPkg::regWidth-1:0]       dispData,
    output logic                              enableOsd,
    output logic [osdPkg::regWidth-1:0]       highlightLine
);
    import osdPkg::*;

    // Register bus between the I2C target and the register map
    logic [regWidth-1:0]      regAddr;
    logic [regWidth-1:0]      regWrData;
    logic                     regWrite;
    logic [regWidth-1:0]      regRdData;

    // Character memory write port
    logic [charAddrWidth-1:0] ramWrAddr;
    logic [regWidth-1:0]      ramWrData;
    logic                     ramWrite;

    // Bus side, the device address is fixed here
    i2cTarget #(
        .deviceAddr(deviceAddr)
    ) target (
        .clk        (clk),
        .rstN       (rstN),
        .scl        (scl),
        .sdaIn      (sdaIn),
        .sdaDriveLow(sdaDriveLow),
        .regAddr    (regAddr),
        .regWrData  (regWrData),
        .regWrite   (regWrite),
        .regRdData  (regRdData)
    );

    osdRegisterFile regs (
        .clk           (clk),
        .rstN          (rstN),
        .regAddr       (regAddr),
        .regWrData     (regWrData),
        .regWrite      (regWrite),
        .regRdData     (regRdData),
        .ramWrAddr     (ramWrAddr),
        .ramWrData     (ramWrData),
        .ramWrite      (ramWrite),
        .enableOsd     (enableOsd),
        .highlightLine (highlightLine),
        .controllerData(controllerData),
        .pllErrors     (pllErrors),
        .frameCounter  (frameCounter),
        .restartCount  (restartCount)
    );

    // Second port belongs to the display renderer
    osdCharRam charRam (
        .clk      (clk),
        .ramWrAddr(ramWrAddr),
        .ramWrData(ramWrData),
        .ramWrite (ramWrite),
        .dispAddr (dispAddr),
        .dispData (dispData)
    );

endmodule

// File: verif/osdControl_assertions.sv
`timescale 1ns/1ns

module osdControlAssertions (
    input logic                         clk,
    input logic                         rstN,
    input logic                         regWrite,
    input logic                         ramWrite,
    input logic                         sdaDriveLow,
    input logic                         sclSync,
    input logic                         enableOsd,
    input logic [osdPkg::regWidth-1:0]  highlightLine
);
    import osdPkg::*;

    // Number of property failures so far, the testbench watches it
    int failCount = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////////////////////////////////////////

    // Every register write is a single cycle pulse
    regWriteSingle: assert property (@(posedge clk) disable iff (!rstN)
        regWrite |=> !regWrite)
    else begin
        $error("regWrite held high for more than one cycle");
        failCount = failCount + 1;
    end

    // The memory write is the registered echo of a register write
    ramWriteFollows: assert property (@(posedge clk) disable iff (!rstN)
        ramWrite |-> $past(regWrite))
    else begin
        $error("ramWrite without a regWrite in the cycle before");
        failCount = failCount + 1;
    end

    ramWriteSingle: assert property (@(posedge clk) disable iff (!rstN)
        ramWrite |=> !ramWrite)
    else begin
        $error("ramWrite held high for more than one cycle");
        failCount = failCount + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus and reset
    ////////////////////////////////////////////////////////////////////////////

    // The target may only move sda while scl is low
    sdaStableSclHigh: assert property (@(posedge clk) disable iff (!rstN)
        sclSync && $past(sclSync) |-> $stable(sdaDriveLow))
    else begin
        $error("sdaDriveLow changed while scl was high");
        failCount = failCount + 1;
    end

    // First cycle out of reset shows the reset levels of the control outputs
    resetOutputs: assert property (@(posedge clk)
        $rose(rstN) |-> !enableOsd && highlightLine == highlightReset)
    else begin
        $error("Control outputs left reset with wrong values");
        failCount = failCount + 1;
    end

endmodule

bind osdControlTop osdControlAssertions busChecks (
    .clk          (clk),
    .rstN         (rstN),
    .regWrite     (regWrite),
    .ramWrite     (ramWrite),
    .sdaDriveLow  (sdaDriveLow),
    .sclSync      (target.sclSync),
    .enableOsd    (enableOsd),
    .highlightLine(highlightLine)
);

// File: verif/osdControlTb.sv
`timescale 1ns/1ns

module osdControlTb;
    import osdPkg::*;

    // Bus address of the OSD target and one that belongs to nobody here
    localparam logic [6:0] targetAddr = 7'h29;
    localparam logic [6:0] foreignAddr = 7'h2A;

    // Run limit from the number of transactions and the length of a bit
    localparam int transactions = 17;
    localparam int bitsPerTransaction = 40;
    localparam int cyclesPerBit = 16;
    localparam int timeoutCycles = 2 * transactions * bitsPerTransaction * cyclesPerBit;

    logic                     clk = 1'b0;
    logic                     rstN = 1'b0;
    logic                     scl = 1'b1;
    logic                     sdaMaster = 1'b1;
    logic                     sdaLine;
    logic                     sdaDriveLow;
    logic [ctrlWidth-1:0]     controllerData = '0;
    logic [regWidth-1:0]      pllErrors = '0;
    logic [frameWidth-1:0]    frameCounter = '0;
    logic [regWidth-1:0]      restartCount = '0;
    logic [charAddrWidth-1:0] dispAddr = '0;
    logic [regWidth-1:0]      dispData;
    logic                     enableOsd;
    logic [regWidth-1:0]      highlightLine;

    // Reference state built from the register map rules
    logic [regWidth-1:0]      charModel [0:(1<<charAddrWidth)-1];
    logic [pageWidth-1:0]     pageModel = '0;
    logic                     enableModel = 1'b0;
    logic [regWidth-1:0]      highlightModel = highlightReset;
    logic [regWidth-1:0]      wrBytes [$];
    logic [regWidth-1:0]      expBytes [$];
    logic [31:0]              lfsrState = 32'h666732e1;
    int                       cycleCount = 0;

    // Open drain bus, the target can only pull the line low
    assign sdaLine = sdaMaster & ~sdaDriveLow;

    osdControlTop #(
        .deviceAddr(targetAddr)
    ) dut (
        .clk           (clk),
        .rstN          (rstN),
        .scl           (scl),
        .sdaIn         (sdaLine),
        .sdaDriveLow   (sdaDriveLow),
        .controllerData(controllerData),
        .pllErrors     (pllErrors),
        .frameCounter  (frameCounter),
        .restartCount  (restartCount),
        .dispAddr      (dispAddr),
        .dispData      (dispData),
        .enableOsd     (enableOsd),
        .highlightLine (highlightLine)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Checking and run control
    ////////////////////////////////////////////////////////////////////////////

    task automatic stopOnFailure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            stopOnFailure($sformatf("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h",
                                    $time, name, expected, actual));
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutCycles) begin
            stopOnFailure("Timeout, the test sequence did not finish within the cycle limit");
        end
    end

    // Property failures in the bound checker end the run straight away
    always @(negedge clk) begin
        if (dut.busChecks.failCount != 0) begin
            stopOnFailure("A bound assertion on the DUT failed");
        end
    end

    // Galois form, taps 32 31 29 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'hD000_0001) : (state >> 1);
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // I2C master, 8 clocks per scl half period
    ////////////////////////////////////////////////////////////////////////////

    task automatic waitCycles(input int count);
        repeat (count) @(posedge clk);
    endtask

    // Entered with the bus idle, leaves scl low
    task automatic startCondition();
        waitCycles(8);
        sdaMaster <= 1'b0;
        waitCycles(8);
        scl <= 1'b0;
    endtask

    task automatic stopCondition();
        waitCycles(4);
        sdaMaster <= 1'b0;
        waitCycles(4);
        scl <= 1'b1;
        waitCycles(8);
        sdaMaster <= 1'b1;
        waitCycles(8);
    endtask

    // Sda only moves in the middle of the low half
    task automatic sendByte(input logic [7:0] data, input logic expectAck);
        for (int i = 7; i >= 0; i--) begin
            waitCycles(4);
            sdaMaster <= data[i];
            waitCycles(4);
            scl <= 1'b1;
            waitCycles(8);
            scl <= 1'b0;
        end
        waitCycles(4);
        sdaMaster <= 1'b1;
        waitCycles(4);
        scl <= 1'b1;
        waitCycles(4);
        @(negedge clk);
        checkValue("sda in the ACK bit", !expectAck, sdaLine);
        waitCycles(4);
        scl <= 1'b0;
    endtask

    // The target puts each bit out a few cycles after scl falls
    task automatic receiveByte(input logic nack, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < 8; i++) begin
            waitCycles(4);
            sdaMaster <= 1'b1;
            waitCycles(4);
            scl <= 1'b1;
            waitCycles(4);
            @(negedge clk);
            value = {value[6:0], sdaLine};
            waitCycles(4);
            scl <= 1'b0;
        end
        waitCycles(4);
        sdaMaster <= nack;
        waitCycles(4);
        scl <= 1'b1;
        waitCycles(8);
        scl <= 1'b0;
    endtask

    task automatic openWrite(input logic [7:0] ptr);
        startCondition();
        sendByte({targetAddr, 1'b0}, 1'b1);
        sendByte(ptr, 1'b1);
    endtask

    task automatic writeRegs(input logic [7:0] ptr);
        openWrite(ptr);
        foreach (wrBytes[i]) begin
            sendByte(wrBytes[i], 1'b1);
        end
        stopCondition();
    endtask

    // Pointer in one transaction, then a burst read NACKed on its last byte
    task automatic readCheck(input logic [7:0] ptr);
        logic [7:0] value;
        logic [7:0] regNum;
        regNum = ptr;
        openWrite(ptr);
        stopCondition();
        startCondition();
        sendByte({targetAddr, 1'b1}, 1'b1);
        foreach (expBytes[i]) begin
            receiveByte(i == expBytes.size() - 1, value);
            checkValue($sformatf("I2C read of register 0x%h", regNum), expBytes[i], value);
            regNum = regNum + 8'd1;
        end
        stopCondition();
    endtask

    task automatic checkDisplay(input logic [charAddrWidth-1:0] addr);
        @(posedge clk);
        dispAddr <= addr;
        @(posedge clk);
        @(negedge clk);
        checkValue($sformatf("dispData at 0x%h", addr), charModel[addr], dispData);
    endtask

    task automatic checkOutputs();
        @(negedge clk);
        checkValue("enableOsd", enableModel, enableOsd);
        checkValue("highlightLine", highlightModel, highlightLine);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]              rnd;
        logic [charAddrWidth-1:0] baseAddr;
        logic [ctrlWidth-1:0]     ctrlValue;
        logic [regWidth-1:0]      pllValue;
        logic [frameWidth-1:0]    frameValue;
        logic [regWidth-1:0]      restartValue;

        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        // Reset levels with the bus still idle
        checkOutputs();

        // Page 5, then a burst that runs off the end of the window into the page and
        // enable registers
        wrBytes.delete();
        wrBytes.push_back(8'h05);
        writeRegs(regPage);
        pageModel = 3'd5;
        wrBytes.delete();
        for (int i = 0; i < 6; i++) begin
            drawBits(8, rnd);
            wrBytes.push_back(rnd[7:0]);
        end
        writeRegs(8'h7C);
        baseAddr = {pageModel, 7'h7C};
        for (int i = 0; i < 4; i++) begin
            charModel[baseAddr + 10'(i)] = wrBytes[i];
        end
        pageModel = wrBytes[4][pageWidth-1:0];
        enableModel = wrBytes[5][0];
        for (int i = 0; i < 4; i++) begin
            checkDisplay(baseAddr + 10'(i));
        end
        checkOutputs();

        // Enable flips and highlight takes a random line, the page read below
        // still holds the value from the burst
        drawBits(16, rnd);
        enableModel = ~enableModel;
        highlightModel = rnd[15:8];
        wrBytes.delete();
        wrBytes.push_back({rnd[7:1], enableModel});
        wrBytes.push_back(highlightModel);
        writeRegs(regEnable);
        checkOutputs();
        expBytes.delete();
        expBytes.push_back({{(regWidth-pageWidth){1'b0}}, pageModel});
        expBytes.push_back({7'd0, enableModel});
        readCheck(regPage);

        // Status levels from the LFSR
        drawBits(12, rnd);
        ctrlValue = rnd[11:0];
        drawBits(8, rnd);
        pllValue = rnd[7:0];
        drawBits(10, rnd);
        frameValue = rnd[9:0];
        drawBits(8, rnd);
        restartValue = rnd[7:0];
        @(posedge clk);
        controllerData <= ctrlValue;
        pllErrors <= pllValue;
        frameCounter <= frameValue;
        restartCount <= restartValue;
        expBytes.delete();
        expBytes.push_back(ctrlValue[11:4]);
        expBytes.push_back({ctrlValue[3:0], 4'h0});
        readCheck(regCtrlHigh);
        expBytes.delete();
        expBytes.push_back(8'h00);
        readCheck(8'h88);
        expBytes.delete();
        expBytes.push_back(pllValue);
        readCheck(regPllErrors);
        expBytes.delete();
        expBytes.push_back(frameValue[7:0]);
        expBytes.push_back({6'd0, frameValue[9:8]});
        readCheck(regFrameLow);
        expBytes.delete();
        expBytes.push_back(restartValue);
        readCheck(regRestarts);

        // Back on page 5 so a stray write would hit a cell with known contents
        wrBytes.delete();
        wrBytes.push_back(8'h05);
        writeRegs(regPage);
        pageModel = 3'd5;

        // Another device's write runs from the last window cell into the enable
        // register, it goes unanswered and changes nothing here
        startCondition();
        sendByte({foreignAddr, 1'b0}, 1'b0);
        sendByte(8'h7F, 1'b0);
        sendByte(~charModel[baseAddr + 10'd3], 1'b0);
        sendByte(8'h05, 1'b0);
        sendByte({7'd0, ~enableModel}, 1'b0);
        stopCondition();
        checkOutputs();
        checkDisplay(baseAddr + 10'd3);

        waitCycles(4);
        if (dut.busChecks.failCount == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            stopOnFailure("A bound assertion on the DUT failed");
        end
    end

endmodule

// File: vlog.f
source/osdPkg.sv
source/i2cTarget.sv
source/osdRegisterFile.sv
source/osdCharRam.sv
source/osdControlTop.sv
verif/osdControl_assertions.sv
verif/osdControlTb.sv

// File: Makefile
TOP := osdControlTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
